// File: tb.f
rtl/frontEndPkg.sv
rtl/instQueueRam.sv
rtl/instDecode.sv
rtl/instBuffer.sv
rtl/decodeBufferTop.sv
sim/decodeBufferTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the decode buffer testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module decodeBufferTb \
  -f tb.f \
  -o decodeBufferSim

./obj_dir/decodeBufferSim > sim.log 2>&1
cat sim.log

if grep -qx "=== PASS ===" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// File: sim/decodeBufferTb.sv
// Decode buffer testbench
`timescale 1ns/1ps

module decodeBufferTb;

  logic                                                       clk;
  logic                                                       arstN_i;
  logic [frontEndPkg::FETCH_WIDTH-1:0]                        fetchValid_i;
  frontEndPkg::fetchInst_t [frontEndPkg::FETCH_WIDTH-1:0]     fetchBundle_i;
  logic                                                       flush_i;
  logic                                                       dispatchStall_i;
  logic                                                       stallFetch_o;
  logic                                                       instBufferReady_o;
  frontEndPkg::decodedPkt_t [frontEndPkg::DISPATCH_WIDTH-1:0] dispatchGroup_o;
  logic [frontEndPkg::BRANCH_COUNT-1:0]                       branchCount_o;

  // Reference model state.
  frontEndPkg::decodedPkt_t modelQ[$];  // Expected buffer contents, oldest first.
  frontEndPkg::decodedPkt_t pendQ[$];   // Group held in the decode register.
  logic                     pendValid;
  int                       modelCount; // Follows the count rule.

  logic [15:0] lfsrState;
  logic [31:0] nextPc;     // Unique pc per slot, so a duplicate shows up.
  int          errorCount;
  int          dispatchCount;
  int          stallCount;
  int          flushCount;

  // Mid-cycle snapshots, checked at the next rising edge.
  logic                                                       checkOn;
  logic                                                       checkGroup;
  logic                                                       afterFlush;
  logic                                                       flushPrev;
  logic                                                       obsReady;
  logic                                                       obsStall;
  logic                                                       expReady;
  logic                                                       expStall;
  frontEndPkg::decodedPkt_t [frontEndPkg::DISPATCH_WIDTH-1:0] obsGroup;
  frontEndPkg::decodedPkt_t [frontEndPkg::DISPATCH_WIDTH-1:0] expGroup;
  logic [frontEndPkg::BRANCH_COUNT-1:0]                       obsBranch;
  logic [frontEndPkg::BRANCH_COUNT-1:0]                       expBranch;

  always #2 clk = ~clk; // 4 ns period.

  decodeBufferTop decodeBufferTop_inst (
    .clk               (clk),
    .arstN_i           (arstN_i),
    .fetchValid_i      (fetchValid_i),
    .fetchBundle_i     (fetchBundle_i),
    .flush_i           (flush_i),
    .dispatchStall_i   (dispatchStall_i),
    .stallFetch_o      (stallFetch_o),
    .instBufferReady_o (instBufferReady_o),
    .dispatchGroup_o   (dispatchGroup_o),
    .branchCount_o     (branchCount_o)
  );

  // 16-bit Fibonacci LFSR step, taps 16 14 13 11.
  function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  // Takes n bits, one LFSR step per bit.
  function automatic logic [31:0] drawBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int b = 0; b < n; b++) begin
      lfsrState = lfsrNext(lfsrState);
      val       = {val[30:0], lfsrState[0]};
    end
    return val;
  endfunction

  // First packet of one instruction by the decode rule.
  function automatic frontEndPkg::decodedPkt_t refPacket(input frontEndPkg::fetchInst_t inst);
    frontEndPkg::decodedPkt_t pkt;
    pkt    = '0;
    pkt.pc = inst.pc;
    case (inst.raw.opcode)
      4'd1:       pkt.op = frontEndPkg::ALU;
      4'd2, 4'd5: pkt.op = frontEndPkg::LOAD;   // A pair becomes loads.
      4'd3:       pkt.op = frontEndPkg::STORE;
      4'd4:       pkt.op = frontEndPkg::BRANCH;
      default:    pkt.op = frontEndPkg::NOP;
    endcase
    pkt.isBranch  = (inst.raw.opcode == 4'd4);
    pkt.dest      = inst.raw.dest;
    pkt.srcA      = inst.raw.srcA;
    pkt.srcB      = inst.raw.srcB;
    pkt.imm       = {3'b000, inst.raw.imm}; // Zero extension.
    pkt.splitHalf = 1'b0;
    return pkt;
  endfunction

  // Expand the presented bundle into the model decode register.
  task automatic loadDecodeModel();
    frontEndPkg::decodedPkt_t pkt;
    pendQ.delete();
    for (int i = 0; i < frontEndPkg::FETCH_WIDTH; i++) begin
      if (fetchValid_i[i]) begin
        pkt = refPacket(fetchBundle_i[i]);
        pendQ.push_back(pkt);
        if (fetchBundle_i[i].raw.opcode == 4'd5) begin
          pkt.dest      = pkt.dest + 5'd1;  // Next register.
          pkt.imm       = pkt.imm + 16'd4;  // Next word.
          pkt.splitHalf = 1'b1;
          pendQ.push_back(pkt);
        end
      end
    end
    pendValid = |fetchValid_i;
  endtask

  // Snapshot the DUT, derive expected values, then step the model through the edge.
  always @(negedge clk) begin
    if (!arstN_i) begin
      checkOn    = 1'b0;
      flushPrev  = 1'b0;
      pendValid  = 1'b0;
      modelCount = 0;
      modelQ.delete();
      pendQ.delete();
    end else begin
      obsReady   = instBufferReady_o;
      obsStall   = stallFetch_o;
      obsGroup   = dispatchGroup_o;
      obsBranch  = branchCount_o;
      expReady   = (modelCount >= 4);
      expStall   = (modelCount > 24);
      expGroup   = '0;
      expBranch  = '0;
      if (modelQ.size() >= 4) begin
        for (int s = 0; s < frontEndPkg::DISPATCH_WIDTH; s++) begin
          expGroup[s] = modelQ[s];
          expBranch   = expBranch + {2'b00, modelQ[s].isBranch};
        end
      end
      checkGroup = expReady && !dispatchStall_i;
      afterFlush = flushPrev;
      flushPrev  = flush_i;
      if (flush_i) begin  // Everything empties at the edge.
        modelQ.delete();
        pendQ.delete();
        pendValid  = 1'b0;
        modelCount = 0;
        flushCount++;
      end else begin
        if (checkGroup) begin
          repeat (4) void'(modelQ.pop_front());
          modelCount = modelCount - 4;
          dispatchCount++;
        end
        if (expStall) begin
          stallCount++;  // Decoder holds, nothing written.
        end else begin
          if (pendValid) begin
            foreach (pendQ[p]) modelQ.push_back(pendQ[p]);
            modelCount = modelCount + pendQ.size();
          end
          loadDecodeModel();
        end
      end
      checkOn = 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (!checkOn) obsReady == expReady)
    else begin
      errorCount++;
      $display("mismatch at %0t: instBufferReady_o expected %0b, got %0b",
               $time, expReady, obsReady);
    end

  assert property (@(posedge clk) disable iff (!checkOn) obsStall == expStall)
    else begin
      errorCount++;
      $display("mismatch at %0t: stallFetch_o expected %0b, got %0b",
               $time, expStall, obsStall);
    end

  assert property (@(posedge clk) disable iff (!checkOn) expReady |-> obsBranch == expBranch)
    else begin
      errorCount++;
      $display("mismatch at %0t: branchCount_o expected %0d, got %0d",
               $time, expBranch, obsBranch);
    end

  assert property (@(posedge clk) disable iff (!checkOn) afterFlush |-> !obsReady)
    else begin
      errorCount++;
      $display("mismatch at %0t: instBufferReady_o after flush expected 0, got %0b",
               $time, obsReady);
    end

  // One check per dispatch slot.
  for (genvar s = 0; s < frontEndPkg::DISPATCH_WIDTH; s++) begin : gSlotCheck
    assert property (@(posedge clk) disable iff (!checkOn)
                     checkGroup |-> obsGroup[s] == expGroup[s])
      else begin
        errorCount++;
        $display("mismatch at %0t: dispatchGroup_o[%0d] expected %h, got %h",
                 $time, s, expGroup[s], obsGroup[s]);
      end
  end

  // Random bundle, slots get consecutive pcs.
  task automatic newBundle(input logic fetchOn);
    fetchValid_i = fetchOn ? 4'(drawBits(4)) : 4'b0000;
    for (int i = 0; i < frontEndPkg::FETCH_WIDTH; i++) begin
      fetchBundle_i[i].pc         = nextPc;
      fetchBundle_i[i].raw.opcode = 4'(drawBits(3)); // 6 and 7 are reserved.
      fetchBundle_i[i].raw.dest   = 5'(drawBits(5));
      fetchBundle_i[i].raw.srcA   = 5'(drawBits(5));
      fetchBundle_i[i].raw.srcB   = 5'(drawBits(5));
      fetchBundle_i[i].raw.imm    = 13'(drawBits(13));
      nextPc = nextPc + 32'd4;
    end
  endtask

  // One cycle, inputs change just after the rising edge.
  task automatic driveCycle(input logic holdDispatch, input logic doFlush, input logic fetchOn);
    @(posedge clk);
    #0.5;
    dispatchStall_i = holdDispatch;
    flush_i         = doFlush;
    if (!stallFetch_o) newBundle(fetchOn); // Bundle stays put while stalled.
  endtask

  task automatic runTraffic(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      driveCycle(drawBits(3) == 0, 1'b0, 1'b1); // Short dispatch stalls now and then.
    end
  endtask

  // Long back-pressure until fetch stalls, then hold it a while.
  task automatic fillToStall();
    int waited;
    waited = 0;
    while (!stallFetch_o && waited < 40) begin
      driveCycle(1'b1, 1'b0, 1'b1);
      waited++;
    end
    if (!stallFetch_o) begin
      errorCount++;
      $display("timeout: fetch stall never rose under dispatch back-pressure");
    end else begin
      repeat (6) driveCycle(1'b1, 1'b0, 1'b1);
    end
  endtask

  task automatic drainBuffer();
    int waited;
    waited = 0;
    while ((instBufferReady_o || waited < 3) && waited < 40) begin
      driveCycle(1'b0, 1'b0, 1'b0);
      waited++;
    end
    if (instBufferReady_o) begin
      errorCount++;
      $display("timeout: buffer did not drain with dispatch open");
    end
  endtask

  task automatic finishRun();
    repeat (2) @(posedge clk);  // Let the last snapshot be checked.
    if (dispatchCount == 0 || stallCount == 0 || flushCount == 0) begin
      errorCount++;
      $display("stimulus did not reach dispatch, fetch stall and flush");
    end
    $display("errors %0d, dispatches %0d, stall cycles %0d, flushes %0d",
             errorCount, dispatchCount, stallCount, flushCount);
    if (errorCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  initial begin
    clk             = 1'b0;
    arstN_i         = 1'b0;
    fetchValid_i    = '0;
    fetchBundle_i   = '0;
    flush_i         = 1'b0;
    dispatchStall_i = 1'b0;
    lfsrState       = 16'd62;
    nextPc          = 32'h0000_1000;
    errorCount      = 0;
    dispatchCount   = 0;
    stallCount      = 0;
    flushCount      = 0;
    checkOn         = 1'b0;
    flushPrev       = 1'b0;
    repeat (16) @(posedge clk);
    #0.5;
    arstN_i = 1'b1;
    for (int round = 0; round < 4; round++) begin
      runTraffic(60);
      fillToStall();
      runTraffic(30);
      driveCycle(1'b0, 1'b1, 1'b1);  // Flush pulse with a full buffer.
    end
    runTraffic(40);
    drainBuffer();
    finishRun();
  end

endmodule

// File: rtl/decodeBufferTop.sv
// Decode to dispatch top level
`timescale 1ns/1ps

module decodeBufferTop (
  input  logic                                                       clk,
  input  logic                                                       arstN_i,
  input  logic [frontEndPkg::FETCH_WIDTH-1:0]                        fetchValid_i,
  input  frontEndPkg::fetchInst_t [frontEndPkg::FETCH_WIDTH-1:0]     fetchBundle_i,
  input  logic                                                       flush_i,
  input  logic                                                       dispatchStall_i,
  output logic                                                       stallFetch_o,
  output logic                                                       instBufferReady_o,
  output frontEndPkg::decodedPkt_t [frontEndPkg::DISPATCH_WIDTH-1:0] dispatchGroup_o,
  output logic [frontEndPkg::BRANCH_COUNT-1:0]                       branchCount_o
);

  logic                                                     decodeReady;   // Write strobe.
  logic [frontEndPkg::DECODE_WIDTH-1:0]                     decodedVector; // Valid run.
  frontEndPkg::decodedPkt_t [frontEndPkg::DECODE_WIDTH-1:0] decodedGroup;

  // Decoder, the only block that honours the fetch stall.
  instDecode instDecode_inst (
    .clk             (clk),
    .arstN_i         (arstN_i),
    .flush_i         (flush_i),
    .stallFetch_i    (stallFetch_o),   // Buffer back-pressure.
    .fetchValid_i    (fetchValid_i),
    .fetchBundle_i   (fetchBundle_i),
    .decodeReady_o   (decodeReady),
    .decodedVector_o (decodedVector),
    .decodedGroup_o  (decodedGroup)
  );

  // Buffer between decode and dispatch.
  instBuffer instBuffer_inst (
    .clk               (clk),
    .arstN_i           (arstN_i),
    .flush_i           (flush_i),
    .dispatchStall_i   (dispatchStall_i),
    .decodeReady_i     (decodeReady),
    .decodedVector_i   (decodedVector),
    .decodedGroup_i    (decodedGroup),
    .stallFetch_o      (stallFetch_o),   // Also seen by fetch.
    .instBufferReady_o (instBufferReady_o),
    .dispatchGroup_o   (dispatchGroup_o),
    .branchCount_o     (branchCount_o)
  );

endmodule

// File: rtl/instBuffer.sv
// Circular instruction buffer
`timescale 1ns/1ps

module instBuffer (
  input  logic                                                       clk,
  input  logic                                                       arstN_i,
  input  logic                                                       flush_i,
  input  logic                                                       dispatchStall_i,
  input  logic                                                       decodeReady_i,
  input  logic [frontEndPkg::DECODE_WIDTH-1:0]                       decodedVector_i,
  input  frontEndPkg::decodedPkt_t [frontEndPkg::DECODE_WIDTH-1:0]   decodedGroup_i,
  output logic                                                       stallFetch_o,
  output logic                                                       instBufferReady_o,
  output frontEndPkg::decodedPkt_t [frontEndPkg::DISPATCH_WIDTH-1:0] dispatchGroup_o,
  output logic [frontEndPkg::BRANCH_COUNT-1:0]                       branchCount_o
);

  logic [frontEndPkg::INST_QUEUE_LOG-1:0] headPtr;  // Oldest packet.
  logic [frontEndPkg::INST_QUEUE_LOG-1:0] tailPtr;  // Next free entry.
  logic [frontEndPkg::INST_QUEUE_LOG:0]   instCount; // Occupancy, 0 to 32.
  logic [frontEndPkg::INST_QUEUE_LOG:0]   countNext;
  logic [frontEndPkg::INST_QUEUE_LOG:0]   writeCount; // Packets written this cycle.
  logic                                   dispatchFire;

  logic [frontEndPkg::DECODE_WIDTH-1:0]   writeEn;
  logic [frontEndPkg::DECODE_WIDTH-1:0][frontEndPkg::INST_QUEUE_LOG-1:0]   writeAddr;
  logic [frontEndPkg::DISPATCH_WIDTH-1:0][frontEndPkg::INST_QUEUE_LOG-1:0] readAddr;

  // Storage with eight write and four read ports.
  instQueueRam instQueueRam_inst (
    .clk      (clk),
    .weVec_i  (writeEn),
    .wrAddr_i (writeAddr),
    .wrData_i (decodedGroup_i),
    .rdAddr_i (readAddr),
    .rdData_o (dispatchGroup_o)
  );

  // Write side, port k lands at tail plus k.
  // The decoder already withholds the strobe under a fetch stall.
  for (genvar k = 0; k < frontEndPkg::DECODE_WIDTH; k++) begin : gWrite
    assign writeEn[k]   = decodeReady_i & decodedVector_i[k];
    assign writeAddr[k] = tailPtr + frontEndPkg::INST_QUEUE_LOG'(k); // Wraps modulo 32.
  end

  // Read side, four consecutive entries from the head.
  for (genvar r = 0; r < frontEndPkg::DISPATCH_WIDTH; r++) begin : gRead
    assign readAddr[r] = headPtr + frontEndPkg::INST_QUEUE_LOG'(r);
  end

  // Level outputs come straight from the registered count.
  assign instBufferReady_o = (instCount >= frontEndPkg::DISPATCH_WIDTH);
  assign stallFetch_o      = (instCount > frontEndPkg::STALL_LEVEL); // Fewer than 8 free.
  assign dispatchFire      = instBufferReady_o & ~dispatchStall_i;

  // Popcount of the written vector and the next occupancy.
  always_comb begin : countUpdate
    writeCount = '0;
    for (int k = 0; k < frontEndPkg::DECODE_WIDTH; k++) begin
      writeCount = writeCount + writeEn[k];
    end
    countNext = instCount + writeCount;
    if (dispatchFire) begin
      countNext = countNext - (frontEndPkg::INST_QUEUE_LOG + 1)'(frontEndPkg::DISPATCH_WIDTH);
    end
  end

  // Pointers and count, flush empties the buffer at the next edge.
  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      headPtr   <= '0;
      tailPtr   <= '0;
      instCount <= '0;
    end else if (flush_i) begin
      headPtr   <= '0;
      tailPtr   <= '0;
      instCount <= '0;
    end else begin
      tailPtr   <= tailPtr + writeCount[frontEndPkg::INST_QUEUE_LOG-1:0];
      instCount <= countNext;
      if (dispatchFire) begin
        headPtr <= headPtr + frontEndPkg::INST_QUEUE_LOG'(frontEndPkg::DISPATCH_WIDTH);
      end
    end
  end

  // Branches in the dispatch window.
  always_comb begin : countBranches
    branchCount_o = '0;
    for (int r = 0; r < frontEndPkg::DISPATCH_WIDTH; r++) begin
      branchCount_o = branchCount_o + dispatchGroup_o[r].isBranch;
    end
  end

endmodule

// File: rtl/instDecode.sv
// Instruction decode and compaction
`timescale 1ns/1ps

module instDecode (
  input  logic                                                clk,
  input  logic                                                arstN_i,
  input  logic                                                flush_i,
  input  logic                                                stallFetch_i,
  input  logic [frontEndPkg::FETCH_WIDTH-1:0]                 fetchValid_i,
  input  frontEndPkg::fetchInst_t [frontEndPkg::FETCH_WIDTH-1:0] fetchBundle_i,
  output logic                                                decodeReady_o,
  output logic [frontEndPkg::DECODE_WIDTH-1:0]                decodedVector_o,
  output frontEndPkg::decodedPkt_t [frontEndPkg::DECODE_WIDTH-1:0] decodedGroup_o
);

  logic                                              groupValid; // Register holds a group.
  logic                                              loadGroup;  // Capture a new bundle.
  logic [frontEndPkg::DECODE_WIDTH-1:0]              nextVector;
  frontEndPkg::decodedPkt_t [frontEndPkg::DECODE_WIDTH-1:0] nextGroup;

  // Decode one raw instruction into its first packet.
  function automatic frontEndPkg::decodedPkt_t decodeOne(input frontEndPkg::fetchInst_t inst);
    frontEndPkg::decodedPkt_t pkt;
    pkt.pc = inst.pc;
    case (frontEndPkg::opType_e'(inst.raw.opcode))
      frontEndPkg::ALU:    pkt.op = frontEndPkg::ALU;
      frontEndPkg::LOAD:   pkt.op = frontEndPkg::LOAD;
      frontEndPkg::STORE:  pkt.op = frontEndPkg::STORE;
      frontEndPkg::BRANCH: pkt.op = frontEndPkg::BRANCH;
      frontEndPkg::LDPAIR: pkt.op = frontEndPkg::LOAD;  // Both halves are plain loads.
      default:             pkt.op = frontEndPkg::NOP;   // Reserved codes.
    endcase
    pkt.isBranch  = (pkt.op == frontEndPkg::BRANCH);
    pkt.dest      = inst.raw.dest;
    pkt.srcA      = inst.raw.srcA;
    pkt.srcB      = inst.raw.srcB;
    pkt.imm       = {{(frontEndPkg::IMM_WIDTH - frontEndPkg::RAW_IMM_WIDTH){1'b0}},
                     inst.raw.imm};
    pkt.splitHalf = 1'b0;
    return pkt;
  endfunction

  // Expand every valid slot in order and pack the packets from slot 0.
  always_comb begin : compactGroup
    logic [frontEndPkg::DECODE_LOG:0] slotIdx;  // Running write slot, reaches 8.
    frontEndPkg::decodedPkt_t         basePkt;
    frontEndPkg::decodedPkt_t         pairPkt;
    logic                             isPair;
    slotIdx   = '0;
    nextGroup = '0;
    for (int i = 0; i < frontEndPkg::FETCH_WIDTH; i++) begin
      basePkt = decodeOne(fetchBundle_i[i]);
      isPair  = (fetchBundle_i[i].raw.opcode == frontEndPkg::LDPAIR);
      // Second half targets the next register and the next word.
      pairPkt           = basePkt;
      pairPkt.dest      = basePkt.dest + 1'b1;
      pairPkt.imm       = basePkt.imm + frontEndPkg::IMM_WIDTH'(frontEndPkg::PAIR_IMM_STEP);
      pairPkt.splitHalf = 1'b1;
      if (fetchValid_i[i]) begin
        nextGroup[slotIdx[frontEndPkg::DECODE_LOG-1:0]] = basePkt;
        slotIdx = slotIdx + 1'b1;
        if (isPair) begin
          nextGroup[slotIdx[frontEndPkg::DECODE_LOG-1:0]] = pairPkt;
          slotIdx = slotIdx + 1'b1;
        end
      end
    end
    // Valid bits form a run from bit 0.
    for (int k = 0; k < frontEndPkg::DECODE_WIDTH; k++) begin
      nextVector[k] = (k < int'(slotIdx));
    end
  end

  assign loadGroup = ~stallFetch_i & (|fetchValid_i);

  // Control half of the decode register. Flush drops the held group.
  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      groupValid      <= 1'b0;
      decodedVector_o <= '0;
    end else if (flush_i) begin
      groupValid      <= 1'b0;
      decodedVector_o <= '0;
    end else if (!stallFetch_i) begin  // Hold everything while stalled.
      groupValid      <= |fetchValid_i;
      decodedVector_o <= nextVector;
    end
  end

  // Packet payload.
  always_ff @(posedge clk) begin
    if (loadGroup) decodedGroup_o <= nextGroup;
  end

  assign decodeReady_o = groupValid & ~stallFetch_i; // Write strobe to the buffer.

endmodule

// File: rtl/instQueueRam.sv
// Instruction buffer storage
`timescale 1ns/1ps

module instQueueRam (
  input  logic                                                       clk,
  input  logic [frontEndPkg::DECODE_WIDTH-1:0]                       weVec_i,
  input  logic [frontEndPkg::DECODE_WIDTH-1:0][frontEndPkg::INST_QUEUE_LOG-1:0]
                                                                     wrAddr_i,
  input  frontEndPkg::decodedPkt_t [frontEndPkg::DECODE_WIDTH-1:0]   wrData_i,
  input  logic [frontEndPkg::DISPATCH_WIDTH-1:0][frontEndPkg::INST_QUEUE_LOG-1:0]
                                                                     rdAddr_i,
  output frontEndPkg::decodedPkt_t [frontEndPkg::DISPATCH_WIDTH-1:0] rdData_o
);

  // Entry array. Pointer logic outside decides which entries are live.
  frontEndPkg::decodedPkt_t mem [frontEndPkg::INST_QUEUE];

  // Eight write ports.
  // Addresses are consecutive from the tail so ports never collide.
  always_ff @(posedge clk) begin
    for (int k = 0; k < frontEndPkg::DECODE_WIDTH; k++) begin
      if (weVec_i[k]) begin
        mem[wrAddr_i[k]] <= wrData_i[k];
      end
    end
  end

  // Four asynchronous read ports for the dispatch window.
  for (genvar r = 0; r < frontEndPkg::DISPATCH_WIDTH; r++) begin : gRead
    assign rdData_o[r] = mem[rdAddr_i[r]];
  end

endmodule

// File: rtl/frontEndPkg.sv
// Front end shared definitions
package frontEndPkg;

  // Machine widths.
  localparam int FETCH_WIDTH    = 4;  // Raw instructions per fetch bundle.
  localparam int DECODE_WIDTH   = 8;  // Packet slots per decode group.
  localparam int DECODE_LOG     = 3;  // Slot index width.
  localparam int DISPATCH_WIDTH = 4;  // Packets leaving the buffer per dispatch.

  // Instruction buffer geometry.
  localparam int INST_QUEUE     = 32; // Buffer entries.
  localparam int INST_QUEUE_LOG = 5;  // Head and tail pointer width.
  localparam int BRANCH_COUNT   = 3;  // Enough to count four branches.

  // Field widths of the raw and decoded formats.
  localparam int PC_WIDTH      = 32;
  localparam int OPCODE_WIDTH  = 4;
  localparam int REG_WIDTH     = 5;
  localparam int RAW_IMM_WIDTH = 13;
  localparam int IMM_WIDTH     = 16;

  // Second half of a load pair reads the next word.
  localparam int PAIR_IMM_STEP = 4;

  // Fetch stall threshold, leaves room for one full decode group.
  localparam int STALL_LEVEL = INST_QUEUE - DECODE_WIDTH;

  // Opcode in raw bits 31 to 28. Unlisted codes decode as NOP.
  typedef enum logic [OPCODE_WIDTH-1:0] {
    NOP    = 4'd0,
    ALU    = 4'd1,
    LOAD   = 4'd2,
    STORE  = 4'd3,
    BRANCH = 4'd4,
    LDPAIR = 4'd5   // Cracked into two LOAD packets.
  } opType_e;

  // Raw 32-bit instruction word.
  typedef struct packed {
    logic [OPCODE_WIDTH-1:0]  opcode; // Bits 31..28.
    logic [REG_WIDTH-1:0]     dest;   // Bits 27..23.
    logic [REG_WIDTH-1:0]     srcA;   // Bits 22..18.
    logic [REG_WIDTH-1:0]     srcB;   // Bits 17..13.
    logic [RAW_IMM_WIDTH-1:0] imm;    // Bits 12..0.
  } rawInst_t;

  // One fetched instruction, 64 bits.
  typedef struct packed {
    logic [PC_WIDTH-1:0] pc;
    rawInst_t            raw;
  } fetchInst_t;

  // Decoded packet as stored in the instruction buffer.
  typedef struct packed {
    logic [PC_WIDTH-1:0]  pc;
    opType_e              op;
    logic                 isBranch;   // Set for BRANCH only.
    logic [REG_WIDTH-1:0] dest;
    logic [REG_WIDTH-1:0] srcA;
    logic [REG_WIDTH-1:0] srcB;
    logic [IMM_WIDTH-1:0] imm;        // Zero-extended raw immediate.
    logic                 splitHalf;  // High for the second half of a pair.
  } decodedPkt_t;

endpackage
